//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_ex_stage
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0

.PHONY: sim clean

# Pass only if the testbench printed its pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qx "Done: no errors"

clean:
	rm -rf $(OBJ_DIR)

//--- build.f
rtl/ex_pkg.sv
rtl/ex_alu.sv
rtl/ex_branch.sv
rtl/ex_lsu.sv
rtl/ex_commit.sv
rtl/ex_stage.sv
test/ex_stage_assert.sv
test/tb_ex_stage.sv

//--- rtl/ex_alu.sv
`timescale 1ns/1ps

module ex_alu import ex_pkg::*; (
	input  inst_t            inst_i,
	input  logic [XLEN-1:0]  op1_i,
	input  logic [XLEN-1:0]  op2_i,
	output logic [XLEN-1:0]  alu_result_o,
	output logic             alu_hit_o,
	output logic             cmp_eq_o,
	output logic             cmp_lt_o,
	output logic             cmp_ltu_o
);

	logic            is_reg;
	logic            reg_f7_ok;
	logic [2:0]      op_f3;
	logic            use_sub;
	logic            use_sra;
	logic [4:0]      shamt;
	logic [XLEN-1:0] sum;
	logic [XLEN-1:0] diff;
	logic [XLEN-1:0] sll_res;
	logic [XLEN-1:0] srl_res;
	logic [XLEN-1:0] sra_mask;
	logic [XLEN-1:0] sra_res;
	logic [XLEN-1:0] int_res;

	assign is_reg    = (inst_i.r.opcode == OPC_OP);
	assign reg_f7_ok = (inst_i.r.funct7 == F7_BASE) || (inst_i.r.funct7 == F7_ALT);

	// OP and OP-IMM share the funct3 field
	assign op_f3   = inst_i.r.funct3;
	assign use_sub = is_reg & inst_i.r.funct7[5];
	// Bit 30 picks arithmetic shift in both forms
	assign use_sra = inst_i.r.funct7[5];

	// Comparison flags shared with the branch unit
	assign cmp_eq_o  = (op1_i == op2_i);
	assign cmp_lt_o  = ($signed(op1_i) < $signed(op2_i));
	assign cmp_ltu_o = (op1_i < op2_i);

	assign shamt   = op2_i[4:0];
	assign sum     = op1_i + op2_i;
	assign diff    = op1_i - op2_i;
	assign sll_res = op1_i << shamt;
	assign srl_res = op1_i >> shamt;

	// Sign fill into the vacated upper bits
	assign sra_mask = {XLEN{1'b1}} >> shamt;
	assign sra_res  = (srl_res & sra_mask) | ({XLEN{op1_i[XLEN-1]}} & ~sra_mask);

	always_comb begin
		case (op_f3)
			F3_ADD:  int_res = use_sub ? diff : sum;
			F3_SLL:  int_res = sll_res;
			F3_SLT:  int_res = {{(XLEN-1){1'b0}}, cmp_lt_o};
			F3_SLTU: int_res = {{(XLEN-1){1'b0}}, cmp_ltu_o};
			F3_XOR:  int_res = op1_i ^ op2_i;
			F3_SR:   int_res = use_sra ? sra_res : srl_res;
			F3_OR:   int_res = op1_i | op2_i;
			default: int_res = op1_i & op2_i;
		endcase
	end

	// Result select per instruction class
	always_comb begin
		alu_hit_o    = 1'b0;
		alu_result_o = '0;
		case (inst_i.r.opcode)
			OPC_OP: begin
				if (reg_f7_ok) begin
					alu_hit_o    = 1'b1;
					alu_result_o = int_res;
				end
			end
			OPC_OP_IMM: begin
				alu_hit_o    = 1'b1;
				alu_result_o = int_res;
			end
			OPC_LUI: begin
				alu_hit_o    = 1'b1;
				alu_result_o = op1_i;
			end
			// Link value or pc-relative upper immediate
			OPC_AUIPC, OPC_JAL, OPC_JALR: begin
				alu_hit_o    = 1'b1;
				alu_result_o = sum;
			end
			default: begin
				alu_hit_o    = 1'b0;
				alu_result_o = '0;
			end
		endcase
	end

endmodule

//--- rtl/ex_branch.sv
`timescale 1ns/1ps

module ex_branch import ex_pkg::*; (
	input  inst_t           inst_i,
	input  logic [XLEN-1:0] eff_addr_i,
	input  logic            cmp_eq_i,
	input  logic            cmp_lt_i,
	input  logic            cmp_ltu_i,
	output logic            jump_en_o,
	output logic [XLEN-1:0] jump_addr_o
);

	logic taken;

	// Condition by funct3 where unused codes never branch
	always_comb begin
		case (inst_i.i.funct3)
			F3_BEQ:  taken = cmp_eq_i;
			F3_BNE:  taken = ~cmp_eq_i;
			F3_BLT:  taken = cmp_lt_i;
			F3_BGE:  taken = ~cmp_lt_i;
			F3_BLTU: taken = cmp_ltu_i;
			F3_BGEU: taken = ~cmp_ltu_i;
			default: taken = 1'b0;
		endcase
	end

	always_comb begin
		case (inst_i.i.opcode)
			OPC_BRANCH: begin
				jump_en_o   = taken;
				jump_addr_o = eff_addr_i;
			end
			// Unconditional jumps
			OPC_JAL, OPC_JALR: begin
				jump_en_o   = 1'b1;
				jump_addr_o = eff_addr_i;
			end
			default: begin
				jump_en_o   = 1'b0;
				jump_addr_o = '0;
			end
		endcase
	end

endmodule

//--- rtl/ex_commit.sv
`timescale 1ns/1ps

module ex_commit import ex_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_i,
	input  logic [REG_ADDR_W-1:0] rd_addr_i,
	input  logic                  rd_wen_i,
	input  logic                  alu_hit_i,
	input  logic [XLEN-1:0]       alu_result_i,
	input  logic                  load_hit_i,
	input  logic [XLEN-1:0]       load_data_i,
	input  logic                  jump_en_i,
	input  logic [XLEN-1:0]       jump_addr_i,
	input  logic                  st_req_i,
	input  logic [STRB_W-1:0]     st_sel_i,
	input  logic [XLEN-1:0]       st_addr_i,
	input  logic [XLEN-1:0]       st_data_i,
	output logic [REG_ADDR_W-1:0] rd_addr_o,
	output logic [XLEN-1:0]       rd_data_o,
	output logic                  rd_wen_o,
	output logic                  jump_en_o,
	output logic [XLEN-1:0]       jump_addr_o,
	output logic                  mem_wr_req_o,
	output logic [STRB_W-1:0]     mem_wr_sel_o,
	output logic [XLEN-1:0]       mem_wr_addr_o,
	output logic [XLEN-1:0]       mem_wr_data_o
);

	logic            wb_en;
	logic [XLEN-1:0] wb_data;

	// Write only when decode asks and the opcode produces a value
	assign wb_en   = rd_wen_i & (alu_hit_i | load_hit_i);
	assign wb_data = load_hit_i ? load_data_i : alu_result_i;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			rd_addr_o     <= '0;
			rd_data_o     <= '0;
			rd_wen_o      <= 1'b0;
			jump_en_o     <= 1'b0;
			jump_addr_o   <= '0;
			mem_wr_req_o  <= 1'b0;
			mem_wr_sel_o  <= '0;
			mem_wr_addr_o <= '0;
			mem_wr_data_o <= '0;
		end else begin
			// Idle write port reads as zero
			rd_wen_o      <= wb_en;
			rd_addr_o     <= wb_en ? rd_addr_i : '0;
			rd_data_o     <= wb_en ? wb_data : '0;
			jump_en_o     <= jump_en_i;
			jump_addr_o   <= jump_addr_i;
			mem_wr_req_o  <= st_req_i;
			mem_wr_sel_o  <= st_sel_i;
			mem_wr_addr_o <= st_addr_i;
			mem_wr_data_o <= st_data_i;
		end
	end

endmodule

//--- rtl/ex_lsu.sv
`timescale 1ns/1ps

module ex_lsu import ex_pkg::*; (
	input  inst_t             inst_i,
	input  logic [XLEN-1:0]   base_addr_i,
	input  logic [XLEN-1:0]   offset_addr_i,
	input  logic [XLEN-1:0]   op2_i,
	input  logic [XLEN-1:0]   mem_rd_data_i,
	output logic [XLEN-1:0]   eff_addr_o,
	output logic [XLEN-1:0]   load_data_o,
	output logic              load_hit_o,
	output logic              st_req_o,
	output logic [STRB_W-1:0] st_sel_o,
	output logic [XLEN-1:0]   st_addr_o,
	output logic [XLEN-1:0]   st_data_o
);

	logic [1:0]  lane;
	logic [7:0]  rd_byte;
	logic [15:0] rd_half;

	assign eff_addr_o = base_addr_i + offset_addr_i;
	assign lane       = eff_addr_o[1:0];

	// Byte and halfword picked from the read word
	always_comb begin
		case (lane)
			2'b00:   rd_byte = mem_rd_data_i[7:0];
			2'b01:   rd_byte = mem_rd_data_i[15:8];
			2'b10:   rd_byte = mem_rd_data_i[23:16];
			default: rd_byte = mem_rd_data_i[31:24];
		endcase
	end

	assign rd_half = lane[1] ? mem_rd_data_i[31:16] : mem_rd_data_i[15:0];

	// Load extension
	always_comb begin
		load_hit_o  = 1'b0;
		load_data_o = '0;
		if (inst_i.i.opcode == OPC_LOAD) begin
			load_hit_o = 1'b1;
			case (inst_i.i.funct3)
				F3_B:    load_data_o = {{(XLEN-8){rd_byte[7]}}, rd_byte};
				F3_H:    load_data_o = {{(XLEN-16){rd_half[15]}}, rd_half};
				F3_W:    load_data_o = mem_rd_data_i;
				F3_BU:   load_data_o = {{(XLEN-8){1'b0}}, rd_byte};
				F3_HU:   load_data_o = {{(XLEN-16){1'b0}}, rd_half};
				default: begin
					load_hit_o  = 1'b0;
					load_data_o = '0;
				end
			endcase
		end
	end

	// Store steering puts the chosen source lane at the bottom
	always_comb begin
		st_req_o  = 1'b0;
		st_sel_o  = '0;
		st_addr_o = '0;
		st_data_o = '0;
		if (inst_i.i.opcode == OPC_STORE) begin
			case (inst_i.i.funct3)
				F3_B: begin
					st_req_o  = 1'b1;
					st_addr_o = eff_addr_o;
					st_sel_o  = 4'b0001 << lane;
					st_data_o = {{(XLEN-8){1'b0}}, op2_i[lane*8 +: 8]};
				end
				F3_H: begin
					st_req_o  = 1'b1;
					st_addr_o = eff_addr_o;
					st_sel_o  = lane[1] ? 4'b1100 : 4'b0011;
					st_data_o = {{(XLEN-16){1'b0}}, op2_i[lane[1]*16 +: 16]};
				end
				F3_W: begin
					st_req_o  = 1'b1;
					st_addr_o = eff_addr_o;
					st_sel_o  = 4'b1111;
					st_data_o = op2_i;
				end
				default: st_req_o = 1'b0;
			endcase
		end
	end

endmodule

//--- rtl/ex_pkg.sv
package ex_pkg;

	// Datapath widths
	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;
	localparam int STRB_W     = 4;

	// Major opcodes
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

	// funct7 values accepted for register operations
	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT  = 7'b0100000;

	// ALU funct3, shared by OP and OP-IMM
	localparam logic [2:0] F3_ADD  = 3'b000;
	localparam logic [2:0] F3_SLL  = 3'b001;
	localparam logic [2:0] F3_SLT  = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR  = 3'b100;
	localparam logic [2:0] F3_SR   = 3'b101;
	localparam logic [2:0] F3_OR   = 3'b110;
	localparam logic [2:0] F3_AND  = 3'b111;

	// Branch conditions
	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	// Load and store access sizes
	localparam logic [2:0] F3_B  = 3'b000;
	localparam logic [2:0] F3_H  = 3'b001;
	localparam logic [2:0] F3_W  = 3'b010;
	localparam logic [2:0] F3_BU = 3'b100;
	localparam logic [2:0] F3_HU = 3'b101;

	// One instruction word with two field layouts
	// The upper bits are funct7 for OP and part of imm12 for OP-IMM
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r;
		struct packed {
			logic [11:0] imm12;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} i;
	} inst_t;

endpackage

//--- rtl/ex_stage.sv
`timescale 1ns/1ps

module ex_stage import ex_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_i,
	input  inst_t                 inst_i,
	input  logic [XLEN-1:0]       op1_i,
	input  logic [XLEN-1:0]       op2_i,
	input  logic [REG_ADDR_W-1:0] rd_addr_i,
	input  logic                  rd_wen_i,
	input  logic [XLEN-1:0]       base_addr_i,
	input  logic [XLEN-1:0]       offset_addr_i,
	input  logic [XLEN-1:0]       mem_rd_data_i,
	output logic [REG_ADDR_W-1:0] rd_addr_o,
	output logic [XLEN-1:0]       rd_data_o,
	output logic                  rd_wen_o,
	output logic                  jump_en_o,
	output logic [XLEN-1:0]       jump_addr_o,
	output logic                  mem_wr_req_o,
	output logic [STRB_W-1:0]     mem_wr_sel_o,
	output logic [XLEN-1:0]       mem_wr_addr_o,
	output logic [XLEN-1:0]       mem_wr_data_o
);

	logic [XLEN-1:0]   eff_addr;
	logic [XLEN-1:0]   alu_result;
	logic              alu_hit;
	logic              cmp_eq;
	logic              cmp_lt;
	logic              cmp_ltu;
	logic              jump_en;
	logic [XLEN-1:0]   jump_addr;
	logic [XLEN-1:0]   load_data;
	logic              load_hit;
	logic              st_req;
	logic [STRB_W-1:0] st_sel;
	logic [XLEN-1:0]   st_addr;
	logic [XLEN-1:0]   st_data;

	ex_alu u_alu (
		.inst_i       (inst_i),
		.op1_i        (op1_i),
		.op2_i        (op2_i),
		.alu_result_o (alu_result),
		.alu_hit_o    (alu_hit),
		.cmp_eq_o     (cmp_eq),
		.cmp_lt_o     (cmp_lt),
		.cmp_ltu_o    (cmp_ltu)
	);

	ex_lsu u_lsu (
		.inst_i        (inst_i),
		.base_addr_i   (base_addr_i),
		.offset_addr_i (offset_addr_i),
		.op2_i         (op2_i),
		.mem_rd_data_i (mem_rd_data_i),
		.eff_addr_o    (eff_addr),
		.load_data_o   (load_data),
		.load_hit_o    (load_hit),
		.st_req_o      (st_req),
		.st_sel_o      (st_sel),
		.st_addr_o     (st_addr),
		.st_data_o     (st_data)
	);

	ex_branch u_branch (
		.inst_i      (inst_i),
		.eff_addr_i  (eff_addr),
		.cmp_eq_i    (cmp_eq),
		.cmp_lt_i    (cmp_lt),
		.cmp_ltu_i   (cmp_ltu),
		.jump_en_o   (jump_en),
		.jump_addr_o (jump_addr)
	);

	// Single output register stage
	ex_commit u_commit (
		.clk           (clk),
		.rst_i         (rst_i),
		.rd_addr_i     (rd_addr_i),
		.rd_wen_i      (rd_wen_i),
		.alu_hit_i     (alu_hit),
		.alu_result_i  (alu_result),
		.load_hit_i    (load_hit),
		.load_data_i   (load_data),
		.jump_en_i     (jump_en),
		.jump_addr_i   (jump_addr),
		.st_req_i      (st_req),
		.st_sel_i      (st_sel),
		.st_addr_i     (st_addr),
		.st_data_i     (st_data),
		.rd_addr_o     (rd_addr_o),
		.rd_data_o     (rd_data_o),
		.rd_wen_o      (rd_wen_o),
		.jump_en_o     (jump_en_o),
		.jump_addr_o   (jump_addr_o),
		.mem_wr_req_o  (mem_wr_req_o),
		.mem_wr_sel_o  (mem_wr_sel_o),
		.mem_wr_addr_o (mem_wr_addr_o),
		.mem_wr_data_o (mem_wr_data_o)
	);

endmodule

//--- test/ex_stage_assert.sv
`timescale 1ns/1ps

module ex_stage_assert import ex_pkg::*; (
	input logic              clk,
	input logic              rst_i,
	input logic              rd_wen_i,
	input logic              jump_en_i,
	input logic              mem_wr_req_i,
	input logic [STRB_W-1:0] mem_wr_sel_i
);

	int fail_count = 0;

	// A store never writes the register file
	store_no_wb: assert property (@(posedge clk) disable iff (rst_i)
		!(mem_wr_req_i && rd_wen_i))
	else begin
		fail_count++;
		$error("store and register write in the same cycle");
	end

	// Every store enables at least one byte lane
	store_has_sel: assert property (@(posedge clk) disable iff (rst_i)
		mem_wr_req_i |-> (mem_wr_sel_i != '0))
	else begin
		fail_count++;
		$error("store request with an empty byte select");
	end

	// Enables are cleared one cycle into reset
	reset_clears: assert property (@(posedge clk)
		rst_i |=> !(rd_wen_i || jump_en_i || mem_wr_req_i))
	else begin
		fail_count++;
		$error("enable still high after reset");
	end

endmodule

bind ex_stage ex_stage_assert u_assert (
	.clk          (clk),
	.rst_i        (rst_i),
	.rd_wen_i     (rd_wen_o),
	.jump_en_i    (jump_en_o),
	.mem_wr_req_i (mem_wr_req_o),
	.mem_wr_sel_i (mem_wr_sel_o)
);

//--- test/tb_ex_stage.sv
`timescale 1ns/1ps

module tb_ex_stage import ex_pkg::*; ();

	localparam int ALU_ROUNDS  = 8;
	// Reset, idle checks, ALU, upper and jump, branch, store, load
	localparam int TEST_CYCLES = 4 + 2 + 19 * ALU_ROUNDS + 16 + 32 + 12 + 64;
	localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;

	logic                  clk;
	logic                  rst_i;
	inst_t                 inst_i;
	logic [XLEN-1:0]       op1_i, op2_i, base_addr_i, offset_addr_i, mem_rd_data_i;
	logic [REG_ADDR_W-1:0] rd_addr_i;
	logic                  rd_wen_i;
	logic [REG_ADDR_W-1:0] rd_addr_o;
	logic [XLEN-1:0]       rd_data_o, jump_addr_o, mem_wr_addr_o, mem_wr_data_o;
	logic                  rd_wen_o, jump_en_o, mem_wr_req_o;
	logic [STRB_W-1:0]     mem_wr_sel_o;

	// Expected outputs of the instruction under test
	logic [REG_ADDR_W-1:0] e_rd_addr;
	logic [XLEN-1:0]       e_rd_data, e_jaddr, e_waddr, e_wdata;
	logic                  e_wen, e_jen, e_req;
	logic [STRB_W-1:0]     e_sel;

	integer seed;
	int     cycles;

	ex_stage dut0 (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		stop_with_failure("timeout: tests did not finish");
	end

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("Done: errors found");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_word(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
		input string what);
		if (got !== exp)
			stop_with_failure($sformatf("FAILED at %0t ns: %s is %h, expected %h",
				$time, what, got, exp));
	endtask

	task automatic check_sel(input logic [STRB_W-1:0] got, input logic [STRB_W-1:0] exp,
		input string what);
		if (got !== exp)
			stop_with_failure($sformatf("FAILED at %0t ns: %s is %b, expected %b",
				$time, what, got, exp));
	endtask

	task automatic check_addr(input logic [REG_ADDR_W-1:0] got,
		input logic [REG_ADDR_W-1:0] exp, input string what);
		if (got !== exp)
			stop_with_failure($sformatf("FAILED at %0t ns: %s is %0d, expected %0d",
				$time, what, got, exp));
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp)
			stop_with_failure($sformatf("FAILED at %0t ns: %s is %b, expected %b",
				$time, what, got, exp));
	endtask

	task automatic check_all(input string tag);
		check_addr(rd_addr_o, e_rd_addr, {tag, " rd_addr"});
		check_word(rd_data_o, e_rd_data, {tag, " rd_data"});
		check_bit(rd_wen_o, e_wen, {tag, " rd_wen"});
		check_bit(jump_en_o, e_jen, {tag, " jump_en"});
		check_word(jump_addr_o, e_jaddr, {tag, " jump_addr"});
		check_bit(mem_wr_req_o, e_req, {tag, " mem_wr_req"});
		check_sel(mem_wr_sel_o, e_sel, {tag, " mem_wr_sel"});
		check_word(mem_wr_addr_o, e_waddr, {tag, " mem_wr_addr"});
		check_word(mem_wr_data_o, e_wdata, {tag, " mem_wr_data"});
	endtask

	task automatic clear_expect;
		e_rd_addr = '0;
		e_rd_data = '0;
		e_wen     = 1'b0;
		e_jen     = 1'b0;
		e_jaddr   = '0;
		e_req     = 1'b0;
		e_sel     = '0;
		e_waddr   = '0;
		e_wdata   = '0;
	endtask

	task automatic expect_write(input logic [REG_ADDR_W-1:0] rd, input logic wen,
		input logic [XLEN-1:0] val);
		e_wen     = wen;
		e_rd_addr = wen ? rd : '0;
		e_rd_data = wen ? val : '0;
	endtask

	function automatic inst_t make_inst(input logic [6:0] f7, input logic [2:0] f3,
		input logic [6:0] opc);
		inst_t w;
		w          = '0;
		w.r.funct7 = f7;
		w.r.funct3 = f3;
		w.r.opcode = opc;
		return w;
	endfunction

	// Drive on the falling edge and sample just after the next rising edge
	task automatic issue(input inst_t in, input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
		input logic [XLEN-1:0] base, input logic [XLEN-1:0] off, input logic [XLEN-1:0] mem,
		input logic [REG_ADDR_W-1:0] rd, input logic wen);
		@(negedge clk);
		inst_i        = in;
		op1_i         = a;
		op2_i         = b;
		base_addr_i   = base;
		offset_addr_i = off;
		mem_rd_data_i = mem;
		rd_addr_i     = rd;
		rd_wen_i      = wen;
		@(posedge clk);
		#1;
	endtask

	function automatic logic [XLEN-1:0] ref_alu(input logic [2:0] f3, input logic alt,
		input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
		case (f3)
			F3_ADD:  return alt ? a - b : a + b;
			F3_SLL:  return a << b[4:0];
			F3_SLT:  return {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
			F3_SLTU: return {{(XLEN-1){1'b0}}, a < b};
			F3_XOR:  return a ^ b;
			F3_SR:   return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
			F3_OR:   return a | b;
			default: return a & b;
		endcase
	endfunction

	task automatic test_reset_unknown;
		clear_expect();
		check_all("after reset");
		// Reserved opcode must not write, jump or store
		issue(make_inst(7'h7f, 3'd7, 7'b1111111), $random(seed), $random(seed),
			32'h0000_0100, 32'h0000_0004, 32'hdead_beef, 5'd31, 1'b1);
		check_all("unknown opcode");
	endtask

	task automatic test_alu;
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		logic [XLEN-1:0] r;
		logic [2:0]      f3;
		logic [6:0]      f7;
		logic            imm;
		logic            alt;
		for (int n = 0; n < ALU_ROUNDS; n++) begin
			for (int k = 0; k < 32; k++) begin
				imm = k[4];
				f3  = k[3:1];
				alt = k[0];
				// Alternate encodings exist only for sub and the right shifts
				if (alt && !(f3 == F3_SR || (!imm && f3 == F3_ADD)))
					continue;
				a  = $random(seed);
				b  = $random(seed);
				r  = $random(seed);
				f7 = alt ? F7_ALT : F7_BASE;
				// Upper immediate bits are free except for shifts
				if (imm && f3 != F3_SLL && f3 != F3_SR)
					f7 = r[31:25];
				issue(make_inst(f7, f3, imm ? OPC_OP_IMM : OPC_OP), a, b, '0, '0, '0,
					r[4:0], r[5]);
				clear_expect();
				expect_write(r[4:0], r[5], ref_alu(f3, alt, a, b));
				check_all($sformatf("alu imm=%0b f3=%0d alt=%0b", imm, f3, alt));
			end
		end
	endtask

	task automatic test_upper_jump;
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		logic [XLEN-1:0] base;
		logic [XLEN-1:0] off;
		logic [6:0]      opc;
		for (int n = 0; n < 16; n++) begin
			a    = $random(seed);
			b    = $random(seed);
			base = $random(seed);
			off  = $random(seed);
			case (n % 4)
				0:       opc = OPC_LUI;
				1:       opc = OPC_AUIPC;
				2:       opc = OPC_JAL;
				default: opc = OPC_JALR;
			endcase
			issue(make_inst(F7_BASE, F3_ADD, opc), a, b, base, off, '0, n[4:0], 1'b1);
			clear_expect();
			expect_write(n[4:0], 1'b1, (opc == OPC_LUI) ? a : a + b);
			if (opc == OPC_JAL || opc == OPC_JALR) begin
				e_jen   = 1'b1;
				e_jaddr = base + off;
			end
			check_all($sformatf("upper/jump opcode %b", opc));
		end
	endtask

	task automatic test_branch;
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		logic [XLEN-1:0] base;
		logic [XLEN-1:0] off;
		logic [2:0]      f3;
		logic            take;
		for (int p = 0; p < 4; p++) begin
			for (int k = 0; k < 8; k++) begin
				f3   = k[2:0];
				a    = $random(seed);
				b    = $random(seed);
				base = $random(seed);
				off  = $random(seed);
				// Mixed signs split signed and unsigned order
				a[XLEN-1] = (p == 1);
				b[XLEN-1] = (p == 3);
				if (p == 0)
					b = a;
				case (f3)
					F3_BEQ:  take = (a == b);
					F3_BNE:  take = (a != b);
					F3_BLT:  take = ($signed(a) < $signed(b));
					F3_BGE:  take = ($signed(a) >= $signed(b));
					F3_BLTU: take = (a < b);
					F3_BGEU: take = (a >= b);
					default: take = 1'b0;
				endcase
				issue(make_inst(F7_BASE, f3, OPC_BRANCH), a, b, base, off, '0, 5'd3, 1'b1);
				clear_expect();
				e_jen   = take;
				e_jaddr = base + off;
				check_all($sformatf("branch pair=%0d f3=%0d", p, f3));
			end
		end
	endtask

	task automatic test_store;
		logic [XLEN-1:0] d;
		logic [XLEN-1:0] base;
		logic [XLEN-1:0] off;
		logic [2:0]      f3;
		for (int s = 0; s < 3; s++) begin
			for (int ln = 0; ln < 4; ln++) begin
				f3   = s[2:0];
				d    = $random(seed);
				base = $random(seed);
				off  = $random(seed);
				// Offset alone picks the lane
				base[1:0] = 2'b00;
				off[1:0]  = ln[1:0];
				issue(make_inst(F7_BASE, f3, OPC_STORE), '0, d, base, off, '0, 5'd7, 1'b1);
				clear_expect();
				e_req   = 1'b1;
				e_waddr = base + off;
				case (f3)
					F3_B: begin
						e_sel   = 4'b0001 << ln;
						e_wdata = (d >> (8 * ln)) & 32'h0000_00ff;
					end
					F3_H: begin
						e_sel   = ln[1] ? 4'b1100 : 4'b0011;
						e_wdata = (d >> (16 * (ln / 2))) & 32'h0000_ffff;
					end
					default: begin
						e_sel   = 4'b1111;
						e_wdata = d;
					end
				endcase
				check_all($sformatf("store f3=%0d lane=%0d", f3, ln));
			end
		end
	endtask

	task automatic test_load;
		logic [XLEN-1:0] m;
		logic [XLEN-1:0] base;
		logic [XLEN-1:0] off;
		logic [XLEN-1:0] sh;
		logic [XLEN-1:0] r;
		logic [7:0]      bt;
		logic [15:0]     hf;
		logic [2:0]      f3;
		logic            hit;
		int              ln;
		for (int n = 0; n < 2; n++) begin
			for (int k = 0; k < 32; k++) begin
				f3   = k[4:2];
				ln   = k % 4;
				m    = $random(seed);
				base = $random(seed);
				off  = $random(seed);
				// Second round makes every byte negative
				if (n == 1)
					m = m | 32'h8080_8080;
				base[1:0] = 2'b00;
				off[1:0]  = ln[1:0];
				sh  = m >> (8 * ln);
				bt  = sh[7:0];
				sh  = m >> (16 * (ln / 2));
				hf  = sh[15:0];
				r   = '0;
				hit = 1'b1;
				case (f3)
					F3_B:    r = {{(XLEN-8){bt[7]}}, bt};
					F3_H:    r = {{(XLEN-16){hf[15]}}, hf};
					F3_W:    r = m;
					F3_BU:   r = {{(XLEN-8){1'b0}}, bt};
					F3_HU:   r = {{(XLEN-16){1'b0}}, hf};
					default: hit = 1'b0;
				endcase
				issue(make_inst(F7_BASE, f3, OPC_LOAD), '0, '0, base, off, m, 5'd9, 1'b1);
				clear_expect();
				expect_write(5'd9, hit, r);
				check_all($sformatf("load f3=%0d lane=%0d", f3, ln));
			end
		end
	endtask

	initial begin
		seed          = 46;
		rst_i         = 1'b1;
		inst_i        = '0;
		op1_i         = '0;
		op2_i         = '0;
		base_addr_i   = '0;
		offset_addr_i = '0;
		mem_rd_data_i = '0;
		rd_addr_i     = '0;
		rd_wen_i      = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_i = 1'b0;
		test_reset_unknown();
		test_alu();
		test_upper_jump();
		test_branch();
		test_store();
		test_load();
		if (dut0.u_assert.fail_count != 0) begin
			stop_with_failure($sformatf("%0d assertion failures",
				dut0.u_assert.fail_count));
		end else begin
			$display("Done: no errors");
			$finish;
		end
	end

endmodule
